// File: alarm_code.f
rtl/alarm_pkg.sv
rtl/second_counter.sv
rtl/equation_stage.sv
rtl/alarm_sequencer.sv
rtl/alarm_code.sv
sim/alarm_code_tb.sv

// File: rtl/alarm_code.sv
module alarm_code #(
    parameter int CYCLES_PER_SECOND = alarm_pkg::CYCLES_PER_SECOND
) (
    input  logic                     Clock,
    input  logic                     reset,
    input  logic                     arm,
    input  alarm_pkg::operand_t      answer,
    output alarm_pkg::stage_status_t status [alarm_pkg::NUM_STAGES],
    output logic                     alarm_on,
    output logic                     done
);

    logic [alarm_pkg::SECONDS_W-1:0]  seconds;
    logic [alarm_pkg::NUM_STAGES-1:0] start;   // one active stage at a time

    second_counter #(
        .CYCLES_PER_SECOND(CYCLES_PER_SECOND)
    ) u_second_counter (
        .Clock   (Clock),
        .reset   (reset),
        .seconds (seconds)
    );

    alarm_sequencer u_alarm_sequencer (
        .Clock    (Clock),
        .reset    (reset),
        .arm      (arm),
        .status   (status),
        .start    (start),
        .alarm_on (alarm_on),
        .done     (done)
    );

    // stage i runs row i of the program table
    for (genvar i = 0; i < alarm_pkg::NUM_STAGES; i++) begin : g_stage
        equation_stage #(
            .EQUATION_ID(i)
        ) u_equation_stage (
            .Clock   (Clock),
            .reset   (reset),
            .start   (start[i]),
            .seconds (seconds),
            .answer  (answer),
            .status  (status[i])
        );
    end

endmodule

// File: rtl/alarm_pkg.sv
package alarm_pkg;

    localparam int DATA_W            = 8;
    localparam int SECONDS_W         = 7;
    localparam int NUM_STAGES        = 2;
    localparam int NUM_STEPS         = 4;
    localparam int CYCLES_PER_SECOND = 50_000_000;

    localparam int STAGE_IDX_W = $clog2(NUM_STAGES);
    localparam int STEP_W      = $clog2(NUM_STEPS);

    localparam logic [STAGE_IDX_W-1:0] LAST_STAGE = STAGE_IDX_W'(NUM_STAGES - 1);
    localparam logic [STEP_W-1:0]      LAST_STEP  = STEP_W'(NUM_STEPS - 1);

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_MUL = 2'd1,
        ALU_DIV = 2'd2      // divide by zero gives 0
    } alu_op_t;

    typedef enum logic [1:0] {
        SEL_X = 2'd0,
        SEL_Y = 2'd1,
        SEL_Z = 2'd2
    } reg_sel_t;

    // where a step result lands
    typedef enum logic [1:0] {
        DEST_X = 2'd0,
        DEST_Y = 2'd1,
        DEST_R = 2'd2
    } dest_t;

    typedef struct packed {
        alu_op_t  op;
        reg_sel_t sel_a;
        reg_sel_t sel_b;
        dest_t    dest;
    } step_t;

    // one row per stage, steps run left to right
    localparam step_t EQ_PROGRAM [NUM_STAGES][NUM_STEPS] = '{
        '{  // (y / z) + (x / z)^2
            '{op: ALU_DIV, sel_a: SEL_X, sel_b: SEL_Z, dest: DEST_X},
            '{op: ALU_MUL, sel_a: SEL_X, sel_b: SEL_X, dest: DEST_X},
            '{op: ALU_DIV, sel_a: SEL_Y, sel_b: SEL_Z, dest: DEST_Y},
            '{op: ALU_ADD, sel_a: SEL_X, sel_b: SEL_Y, dest: DEST_R}
        },
        '{  // x*x*z + x*y
            '{op: ALU_MUL, sel_a: SEL_X, sel_b: SEL_Y, dest: DEST_Y},
            '{op: ALU_MUL, sel_a: SEL_X, sel_b: SEL_X, dest: DEST_X},
            '{op: ALU_MUL, sel_a: SEL_X, sel_b: SEL_Z, dest: DEST_X},
            '{op: ALU_ADD, sel_a: SEL_X, sel_b: SEL_Y, dest: DEST_R}
        }
    };

    // user answer, same bundle goes to every stage
    typedef struct packed {
        logic [DATA_W-1:0] value;
        logic              go;
    } operand_t;

    typedef struct packed {
        logic              solved;
        logic [DATA_W-1:0] target;
    } stage_status_t;

    typedef enum logic [1:0] {
        SEQ_IDLE     = 2'd0,
        SEQ_RUN      = 2'd1,
        SEQ_FINISHED = 2'd2
    } seq_state_t;

    typedef enum logic [3:0] {
        ST_IDLE, ST_CAPTURE,
        ST_LOAD_X, ST_WAIT_X,
        ST_LOAD_Y, ST_WAIT_Y,
        ST_LOAD_Z, ST_WAIT_Z,
        ST_STEP, ST_COMPARE, ST_COMPLETE, ST_CLEAR
    } stage_state_t;

endpackage

// File: rtl/alarm_sequencer.sv
module alarm_sequencer (
    input  logic                              Clock,
    input  logic                              reset,
    input  logic                              arm,
    input  alarm_pkg::stage_status_t          status [alarm_pkg::NUM_STAGES],
    output logic [alarm_pkg::NUM_STAGES-1:0] start,
    output logic                              alarm_on,
    output logic                              done
);

    alarm_pkg::seq_state_t state;
    alarm_pkg::seq_state_t state_next;

    logic [alarm_pkg::STAGE_IDX_W-1:0] idx;     // active stage
    logic [alarm_pkg::STAGE_IDX_W-1:0] idx_next;

    always_comb begin
        state_next = state;
        idx_next   = idx;
        case (state)
            alarm_pkg::SEQ_IDLE: begin
                if (arm) begin
                    state_next = alarm_pkg::SEQ_RUN;
                    idx_next   = '0;
                end
            end
            alarm_pkg::SEQ_RUN: begin
                if (!arm) begin
                    state_next = alarm_pkg::SEQ_IDLE;   // disarmed mid chain
                end else if (status[idx].solved) begin
                    if (idx == alarm_pkg::LAST_STAGE) begin
                        state_next = alarm_pkg::SEQ_FINISHED;
                    end else begin
                        idx_next = idx + 1'b1;
                    end
                end
            end
            alarm_pkg::SEQ_FINISHED: begin
                if (!arm) state_next = alarm_pkg::SEQ_IDLE;
            end
            default: state_next = alarm_pkg::SEQ_IDLE;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            state <= alarm_pkg::SEQ_IDLE;
            idx   <= '0;
        end else begin
            state <= state_next;
            idx   <= idx_next;
        end
    end

    always_comb begin
        start = '0;
        if (state == alarm_pkg::SEQ_RUN) begin
            start[idx] = 1'b1;
        end
    end

    assign alarm_on = (state == alarm_pkg::SEQ_RUN);
    assign done     = (state == alarm_pkg::SEQ_FINISHED);

    // the active stage only moves on to the next one, after it was solved
    a_start_advance: assert property (@(posedge Clock) disable iff (reset)
        alarm_on && $past(alarm_on) && start != $past(start)
        |-> start == ($past(start) << 1) && $past(status[idx].solved));

    // done only after the last stage reported solved
    a_done_after_last: assert property (@(posedge Clock) disable iff (reset)
        $rose(done) |-> $past(status[alarm_pkg::LAST_STAGE].solved));

endmodule

// File: rtl/equation_stage.sv
module equation_stage #(
    parameter int EQUATION_ID = 0
) (
    input  logic                             Clock,
    input  logic                             reset,
    input  logic                             start,
    input  logic [alarm_pkg::SECONDS_W-1:0] seconds,
    input  alarm_pkg::operand_t              answer,
    output alarm_pkg::stage_status_t         status
);

    alarm_pkg::stage_state_t state;
    alarm_pkg::stage_state_t state_next;

    logic [alarm_pkg::STEP_W-1:0] step_cnt;
    alarm_pkg::step_t             step;

    logic [alarm_pkg::DATA_W-1:0] x;
    logic [alarm_pkg::DATA_W-1:0] y;
    logic [alarm_pkg::DATA_W-1:0] z;
    logic [alarm_pkg::DATA_W-1:0] result;
    logic [alarm_pkg::DATA_W-1:0] target;
    logic [alarm_pkg::DATA_W-1:0] alu_a;
    logic [alarm_pkg::DATA_W-1:0] alu_b;
    logic [alarm_pkg::DATA_W-1:0] alu_out;

    logic match;
    logic capture_target;

    function automatic logic [alarm_pkg::DATA_W-1:0] pick(
        input alarm_pkg::reg_sel_t          sel,
        input logic [alarm_pkg::DATA_W-1:0] x_val,
        input logic [alarm_pkg::DATA_W-1:0] y_val,
        input logic [alarm_pkg::DATA_W-1:0] z_val
    );
        case (sel)
            alarm_pkg::SEL_X: return x_val;
            alarm_pkg::SEL_Y: return y_val;
            alarm_pkg::SEL_Z: return z_val;
            default:          return '0;
        endcase
    endfunction

    assign step  = alarm_pkg::EQ_PROGRAM[EQUATION_ID][step_cnt];
    assign alu_a = pick(step.sel_a, x, y, z);
    assign alu_b = pick(step.sel_b, x, y, z);

    always_comb begin
        case (step.op)
            alarm_pkg::ALU_ADD: alu_out = alu_a + alu_b;
            alarm_pkg::ALU_MUL: alu_out = alu_a * alu_b;    // low byte only
            alarm_pkg::ALU_DIV: alu_out = (alu_b == '0) ? '0 : alu_a / alu_b;
            default:            alu_out = '0;
        endcase
    end

    assign match = (result == target);

    // first target on start, fresh one after each miss
    assign capture_target = start &&
        (state == alarm_pkg::ST_IDLE || state == alarm_pkg::ST_CAPTURE);

    always_comb begin
        state_next = state;
        case (state)
            alarm_pkg::ST_IDLE:     if (start) state_next = alarm_pkg::ST_LOAD_X;
            alarm_pkg::ST_CAPTURE:  state_next = alarm_pkg::ST_LOAD_X;
            alarm_pkg::ST_LOAD_X:   if (answer.go) state_next = alarm_pkg::ST_WAIT_X;
            alarm_pkg::ST_WAIT_X:   if (!answer.go) state_next = alarm_pkg::ST_LOAD_Y;
            alarm_pkg::ST_LOAD_Y:   if (answer.go) state_next = alarm_pkg::ST_WAIT_Y;
            alarm_pkg::ST_WAIT_Y:   if (!answer.go) state_next = alarm_pkg::ST_LOAD_Z;
            alarm_pkg::ST_LOAD_Z:   if (answer.go) state_next = alarm_pkg::ST_WAIT_Z;
            alarm_pkg::ST_WAIT_Z:   if (!answer.go) state_next = alarm_pkg::ST_STEP;
            alarm_pkg::ST_STEP: begin
                if (step_cnt == alarm_pkg::LAST_STEP) begin
                    state_next = alarm_pkg::ST_COMPARE;
                end
            end
            alarm_pkg::ST_COMPARE: begin
                state_next = match ? alarm_pkg::ST_COMPLETE : alarm_pkg::ST_CLEAR;
            end
            alarm_pkg::ST_COMPLETE: state_next = alarm_pkg::ST_COMPLETE;   // hold until start drops
            alarm_pkg::ST_CLEAR:    state_next = alarm_pkg::ST_CAPTURE;
            default:                state_next = alarm_pkg::ST_IDLE;
        endcase
        if (!start) begin
            state_next = alarm_pkg::ST_IDLE;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            state    <= alarm_pkg::ST_IDLE;
            step_cnt <= '0;
        end else begin
            state    <= state_next;
            step_cnt <= (state == alarm_pkg::ST_STEP) ? step_cnt + 1'b1 : '0;
        end
    end

    // operand, result and target registers
    always_ff @(posedge Clock) begin
        if (reset) begin
            x      <= '0;
            y      <= '0;
            z      <= '0;
            result <= '0;
            target <= '0;
        end else begin
            if (capture_target) begin
                target <= {{(alarm_pkg::DATA_W - alarm_pkg::SECONDS_W){1'b0}}, seconds};
            end
            case (state)
                alarm_pkg::ST_LOAD_X: begin
                    if (answer.go) x <= answer.value;
                end
                alarm_pkg::ST_LOAD_Y: begin
                    if (answer.go) y <= answer.value;
                end
                alarm_pkg::ST_LOAD_Z: begin
                    if (answer.go) z <= answer.value;
                end
                alarm_pkg::ST_STEP: begin
                    case (step.dest)
                        alarm_pkg::DEST_X: x <= alu_out;
                        alarm_pkg::DEST_Y: y <= alu_out;
                        alarm_pkg::DEST_R: result <= alu_out;
                        default: ;
                    endcase
                end
                alarm_pkg::ST_CLEAR: begin
                    x      <= '0;
                    y      <= '0;
                    z      <= '0;
                    result <= '0;
                end
                default: ;
            endcase
        end
    end

    assign status.target = target;
    assign status.solved = (state == alarm_pkg::ST_COMPLETE) && start;

    // solved only ever follows a compare that ran under a held start
    a_solved_start: assert property (@(posedge Clock) disable iff (reset)
        status.solved |-> $past(start));

    a_go_known: assert property (@(posedge Clock) disable iff (reset)
        !$isunknown(answer.go));

    // compare follows a full program, step 0 exactly NUM_STEPS cycles back
    a_step_count: assert property (@(posedge Clock) disable iff (reset)
        state == alarm_pkg::ST_COMPARE
        |-> $past(state, alarm_pkg::NUM_STEPS) == alarm_pkg::ST_STEP
            && $past(step_cnt, alarm_pkg::NUM_STEPS) == '0);

endmodule

// File: rtl/second_counter.sv
module second_counter #(
    parameter int CYCLES_PER_SECOND = alarm_pkg::CYCLES_PER_SECOND
) (
    input  logic                             Clock,
    input  logic                             reset,
    output logic [alarm_pkg::SECONDS_W-1:0] seconds
);

    localparam int PRESCALE_W = $clog2(CYCLES_PER_SECOND);

    logic [PRESCALE_W-1:0] prescale;
    logic                  tick;

    assign tick = (prescale == PRESCALE_W'(CYCLES_PER_SECOND - 1));

    always_ff @(posedge Clock) begin
        if (reset) begin
            prescale <= '0;
            seconds  <= '0;
        end else begin
            if (tick) begin
                prescale <= '0;
                seconds  <= seconds + 1'b1;     // wraps at 128
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the alarm_code testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=alarm_code_sim

rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module alarm_code_tb \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f alarm_code.f > "$LOG" 2>&1 \
    && "./$BUILD_DIR/$SIM_BIN" >> "$LOG" 2>&1

cat "$LOG"

grep -q "^TEST PASSED$" "$LOG" && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed, see $LOG"; exit 1; }

// File: sim/alarm_code_tb.sv
module alarm_code_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_CPS    = 16;
    localparam int WAIT_LIMIT  = 200;           // cycles per wait
    localparam int DRAW_LIMIT  = 200_000;
    localparam int Z0_DRAWS    = 512;           // early draws try z = 0
    localparam int RUN_LIMIT   = 2_000_000;     // ns
    localparam int PROBE_ALARM = alarm_pkg::NUM_STAGES;
    localparam int PROBE_DONE  = alarm_pkg::NUM_STAGES + 1;

    typedef logic [alarm_pkg::DATA_W-1:0] data_t;

    typedef struct packed {
        data_t x;
        data_t y;
        data_t z;
    } triple_t;

    logic                     Clock;
    logic                     reset;
    logic                     arm;
    alarm_pkg::operand_t      answer;
    alarm_pkg::stage_status_t status [alarm_pkg::NUM_STAGES];
    logic                     alarm_on;
    logic                     done;

    int      seed         = 32'hf2d2;
    int      cyc          = 0;      // cycles since reset release
    int      check_count  = 0;
    int      check_errors = 0;
    int      flow_errors  = 0;
    string   test_name    = "init";
    triple_t sent [alarm_pkg::NUM_STAGES] = '{default: '0};    // last triple per stage
    logic    solved_seen [alarm_pkg::NUM_STAGES] = '{default: 1'b0};

    alarm_code #(
        .CYCLES_PER_SECOND(TEST_CPS)
    ) UUT (
        .Clock    (Clock),
        .reset    (reset),
        .arm      (arm),
        .answer   (answer),
        .status   (status),
        .alarm_on (alarm_on),
        .done     (done)
    );

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    always @(posedge Clock) begin
        if (reset) cyc <= 0;
        else cyc <= cyc + 1;
    end

    // both equations mod 256, any division by zero gives 0
    function automatic data_t expected_result(input int eq_id, input triple_t t);
        int x;
        int y;
        int z;
        int r;
        x = int'(t.x);
        y = int'(t.y);
        z = int'(t.z);
        if (eq_id == 0) begin
            if (z == 0) r = 0;
            else r = (y / z) + (x / z) * (x / z);
        end else begin
            r = x * x * z + x * y;
        end
        return r[alarm_pkg::DATA_W-1:0];
    endfunction

    // seconds count right after the edge that left cyc at c
    function automatic int seconds_at(input int c);
        return (c / TEST_CPS) % (1 << alarm_pkg::SECONDS_W);
    endfunction

    function automatic logic probe(input int sel);
        if (sel == PROBE_ALARM) return alarm_on;
        if (sel == PROBE_DONE) return done;
        return status[sel].solved;
    endfunction

    function automatic string probe_name(input int sel);
        if (sel == PROBE_ALARM) return "alarm_on";
        if (sel == PROBE_DONE) return "done";
        return $sformatf("stage %0d solved", sel);
    endfunction

    task automatic end_run();
        $display("checks %0d, check errors %0d, flow errors %0d",
                 check_count, check_errors, flow_errors);
        if (check_errors == 0 && flow_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic next_cycle();
        @(posedge Clock);
        #1;     // drive and sample point
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        check_count++;
        assert (expected == actual) else begin
            check_errors++;
            $display("** Error %s: %s expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic wait_level(input int sel, input logic level, output int cycles);
        cycles = 0;
        while (probe(sel) !== level && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (probe(sel) !== level) begin
            flow_errors++;
            $display("%s: %s did not go to %0b within %0d cycles",
                     test_name, probe_name(sel), level, WAIT_LIMIT);
        end
    endtask

    // target must be a seconds value seen since cycle c_lo
    task automatic check_target(input int stage, input int c_lo);
        logic ok;
        int   tgt;
        tgt = int'(status[stage].target);
        ok  = 1'b0;
        for (int k = c_lo; k <= cyc; k++) begin
            if (seconds_at(k) == tgt) ok = 1'b1;
        end
        check_count++;
        assert (ok) else begin
            check_errors++;
            $display("** Error %s: stage %0d target expected %0d..%0d, actual %0d",
                     test_name, stage, seconds_at(c_lo), seconds_at(cyc), tgt);
        end
        check_value("target msb", 0, int'(status[stage].target[alarm_pkg::DATA_W-1]));
    endtask

    task automatic draw_triple(input int stage, input data_t target, input logic want_match,
                               output triple_t t);
        int    n;
        int    r;
        logic  found;
        data_t res;
        n     = 0;
        found = 1'b0;
        t     = '0;
        while (!found && n < DRAW_LIMIT) begin
            r   = $random(seed);
            t.x = r[7:0];
            t.y = r[15:8];
            if (n < Z0_DRAWS) t.z = '0;
            else t.z = r[23:16];
            res = expected_result(stage, t);
            if (want_match) found = (res == target);
            else found = (res != target);
            n++;
        end
        if (!found) begin
            flow_errors++;
            $display("%s: no operand triple found for stage %0d target %0d",
                     test_name, stage, target);
        end
    endtask

    task automatic press_go(input data_t value);
        answer.value = value;
        answer.go    = 1'b1;
        next_cycle();
        answer.go    = 1'b0;
    endtask

    task automatic enter_triple(input triple_t t);
        press_go(t.x);
        next_cycle();
        press_go(t.y);
        next_cycle();
        press_go(t.z);      // returns with go just released
    endtask

    task automatic run_chain(input logic with_wrong);
        triple_t t;
        data_t   t1_before;
        logic    seen;
        int      c_mark;
        int      n;

        test_name = "arm";
        t1_before = status[1].target;
        c_mark    = cyc;
        arm       = 1'b1;
        wait_level(PROBE_ALARM, 1'b1, n);
        next_cycle();                       // stage 0 captures here
        check_target(0, c_mark);
        check_value("stage 1 solved", 0, int'(status[1].solved));
        check_value("stage 1 target held", int'(t1_before), int'(status[1].target));

        if (with_wrong) begin
            test_name = "stage 0 wrong triple";
            draw_triple(0, status[0].target, 1'b0, t);
            sent[0] = t;
            repeat (TEST_CPS) next_cycle();     // seconds move past the old target
            enter_triple(t);
            c_mark = cyc;
            seen   = 1'b0;
            repeat (12) begin
                next_cycle();
                if (status[0].solved) seen = 1'b1;
            end
            check_value("solved after wrong triple", 0, int'(seen));
            check_target(0, c_mark);        // fresh target after clear
        end

        test_name = "stage 0 solve";
        draw_triple(0, status[0].target, 1'b1, t);
        sent[0] = t;
        enter_triple(t);
        wait_level(0, 1'b1, n);
        check_value("solve latency", 6, n);
        c_mark = cyc;
        wait_level(0, 1'b0, n);
        next_cycle();

        test_name = "stage 1 capture";
        check_target(1, c_mark);
        check_value("alarm_on", 1, int'(alarm_on));

        test_name = "stage 1 solve";
        draw_triple(1, status[1].target, 1'b1, t);
        sent[1] = t;
        enter_triple(t);
        wait_level(1, 1'b1, n);
        check_value("solve latency", 6, n);
        wait_level(PROBE_DONE, 1'b1, n);
        check_value("alarm_on", 0, int'(alarm_on));
        check_value("stage 0 solved", 0, int'(status[0].solved));
        check_value("stage 1 solved", 0, int'(status[1].solved));
    endtask

    task automatic check_idle(input logic targets_zero);
        check_value("alarm_on", 0, int'(alarm_on));
        check_value("done", 0, int'(done));
        for (int i = 0; i < alarm_pkg::NUM_STAGES; i++) begin
            check_value($sformatf("stage %0d solved", i), 0, int'(status[i].solved));
            if (targets_zero) begin
                check_value($sformatf("stage %0d target", i), 0, int'(status[i].target));
            end
        end
    endtask

    // every rising solved has to come from a triple that meets the target
    always begin
        @(posedge Clock);
        #2;
        for (int i = 0; i < alarm_pkg::NUM_STAGES; i++) begin
            if (status[i].solved && !solved_seen[i]) begin
                check_count++;
                assert (expected_result(i, sent[i]) == status[i].target) else begin
                    check_errors++;
                    $display("** Error %s: stage %0d solve expected %0d, actual target %0d",
                             test_name, i, expected_result(i, sent[i]), status[i].target);
                end
            end
            solved_seen[i] = status[i].solved;
        end
    end

    initial begin
        int n;
        reset  = 1'b1;
        arm    = 1'b0;
        answer = '0;
        next_cycle();
        next_cycle();
        reset = 1'b0;

        test_name = "after reset";
        check_idle(1'b1);
        next_cycle();
        check_idle(1'b1);

        run_chain(1'b0);    // target still 0, so z = 0 can solve stage 0

        test_name = "disarm";
        arm = 1'b0;
        wait_level(PROBE_DONE, 1'b0, n);
        check_idle(1'b0);

        run_chain(1'b1);    // second pass from stage 0, with a miss first
        test_name = "second disarm";
        arm = 1'b0;
        wait_level(PROBE_DONE, 1'b0, n);
        check_idle(1'b0);

        test_name = "second reset";
        reset = 1'b1;
        next_cycle();
        next_cycle();
        reset = 1'b0;
        check_idle(1'b1);

        end_run();
    end

    initial begin
        #(RUN_LIMIT);
        flow_errors++;
        $display("simulation ran past its time limit of %0d ns", RUN_LIMIT);
        end_run();
    end

endmodule
